//--- periph_input.txt
# op address wdata gpio_i err rdata, all fields after op in hex
# gpio_i is held on the pins while the request is in flight
read  F0000000 00000000 00 0 18800000
read  F0000004 00000000 00 0 A8840100
read  F0000008 00000000 00 0 18609100
read  F0000024 00000000 00 0 44000000
read  F0000030 00000000 00 0 DEADBEEF
read  F000003C 00000000 00 0 87654321
read  F0000050 00000000 00 0 00000000
write F0000000 12345678 00 1 00000000
read  00000000 00000000 00 1 00000000
read  F0000100 00000000 00 1 00000000
write 91000000 000000A5 00 0 00000000
write 91000001 0000F000 00 0 00000000
read  91000001 00000000 00 0 0000F000
read  91000000 00000000 00 0 000000A0
read  91000002 00000000 3C 0 00AC0000
read  91000003 00000000 3C 0 F0000000
write 91000002 00C30000 3C 0 00000000
write 91000003 0F000000 3C 0 00000000
read  91000000 00000000 3C 0 00000033
read  91000001 00000000 3C 0 00000F00
read  F0000038 00000000 3C 0 12345678
read  91000004 00000000 3C 1 00000000
write 92000000 00000001 3C 1 00000000

//--- periph_top.f
+incdir+.
periph_pkg.sv
credit_fifo.sv
addr_decode_stage.sv
boot_rom.sv
gpio_regs.sv
target_access_stage.sv
periph_top.sv
tb_periph_top.sv

//--- Bender.yml
package:
  name: periph_top

sources:
  - include_dirs:
      - .
    files:
      - periph_pkg.sv
      - credit_fifo.sv
      - addr_decode_stage.sv
      - boot_rom.sv
      - gpio_regs.sv
      - target_access_stage.sv
      - periph_top.sv
  - target: test
    files:
      - tb_periph_top.sv

//--- tb_periph_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_periph_top;

	localparam int req_depth = 4;
	localparam int rsp_depth = 4;
	localparam int rom_aw = 6;
	localparam int rsp_credits = 2;
	localparam int wait_limit = 200;
	localparam logic [31:0] rng_seed = 32'h9778c0d9;

	logic                 wb_clk_i;
	logic                 rst_n_i;
	logic                 req_valid_i;
	logic                 req_we_i;
	periph_pkg::bus_adr_t req_adr_i;
	periph_pkg::bus_dat_t req_dat_i;
	logic                 req_credit_o;
	logic                 rsp_valid_o;
	logic                 rsp_err_o;
	periph_pkg::bus_dat_t rsp_dat_o;
	logic                 rsp_credit_i;
	periph_pkg::byte_t    gpio_i;
	periph_pkg::byte_t    gpio_o;
	periph_pkg::byte_t    gpio_oe_o;

	logic [32:0] exp_q [$];
	int          req_credits;
	int          ret_pending;
	int          req_sent;
	int          req_credit_pulses;
	int          rsp_seen;
	int          rsp_returned;
	int          value_errors;
	int          protocol_errors;
	int          timeouts;
	// GPIO register contents expected from the writes sent so far
	logic [7:0]  model_dat;
	logic [7:0]  model_dir;

	periph_top #(
		.req_depth   (req_depth),
		.rsp_depth   (rsp_depth),
		.rom_aw      (rom_aw),
		.rsp_credits (rsp_credits)
	) u_periph_top (
		.wb_clk_i     (wb_clk_i),
		.rst_n_i      (rst_n_i),
		.req_valid_i  (req_valid_i),
		.req_we_i     (req_we_i),
		.req_adr_i    (req_adr_i),
		.req_dat_i    (req_dat_i),
		.req_credit_o (req_credit_o),
		.rsp_valid_o  (rsp_valid_o),
		.rsp_err_o    (rsp_err_o),
		.rsp_dat_o    (rsp_dat_o),
		.rsp_credit_i (rsp_credit_i),
		.gpio_i       (gpio_i),
		.gpio_o       (gpio_o),
		.gpio_oe_o    (gpio_oe_o)
	);

	initial begin
		wb_clk_i = 1'b0;
		forever #2 wb_clk_i = ~wb_clk_i;
	end

	function automatic logic [31:0] xorshift32(logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
		if (got !== expected) begin
			value_errors++;
			$display("ERROR at %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, got,
				expected);
		end
	endtask

	task automatic finish_run();
		$display("Errors: %0d value, %0d protocol, %0d timeout", value_errors,
			protocol_errors, timeouts);
		if (value_errors + protocol_errors + timeouts == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	endtask

	task automatic report_timeout(string what);
		timeouts++;
		$display("Timeout at %0t ns while waiting for %s", $time, what);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Request side, called on a rising edge
	//////////////////////////////////////////////////////////////////////
	task automatic send_request(logic we, logic [31:0] adr, logic [31:0] dat,
		logic [32:0] exp_rsp);
		int         waited;
		logic [7:0] lane_byte;
		waited = 0;
		while (req_credits == 0 && timeouts == 0) begin
			req_valid_i <= 1'b0;
			@(posedge wb_clk_i);
			waited++;
			if (waited > wait_limit)
				report_timeout("a request credit");
		end
		if (timeouts == 0) begin
			req_valid_i <= 1'b1;
			req_we_i <= we;
			req_adr_i <= adr;
			req_dat_i <= dat;
			req_credits--;
			exp_q.push_back(exp_rsp);
			// GPIO window is one word, bit 0 picks data or direction
			if (we && (adr[31:2] == 30'h2440_0000)) begin
				lane_byte = dat[8*adr[1:0] +: 8];
				if (adr[0])
					model_dir = lane_byte;
				else
					model_dat = lane_byte;
			end
			@(posedge wb_clk_i);
		end
	endtask

	// Waits for every outstanding response, then checks the pins
	task automatic drain_responses();
		int waited;
		waited = 0;
		req_valid_i <= 1'b0;
		while (exp_q.size() != 0 && timeouts == 0) begin
			@(posedge wb_clk_i);
			waited++;
			if (waited > wait_limit)
				report_timeout("outstanding responses");
		end
		if (timeouts == 0) begin
			check_value("gpio_o", gpio_o, model_dat);
			check_value("gpio_oe_o", gpio_oe_o, model_dir);
		end
	endtask

	// Response credits come back after a random delay
	initial begin : return_rsp_credits
		logic [31:0] rng;
		int          delay;
		rng = rng_seed;
		delay = 0;
		rsp_credit_i = 1'b0;
		forever begin
			@(posedge wb_clk_i);
			if (delay > 0) begin
				delay--;
				rsp_credit_i <= 1'b0;
			end else if (ret_pending > 0) begin
				rsp_credit_i <= 1'b1;
				ret_pending--;
				rng = xorshift32(rng);
				delay = rng % 4;
			end else begin
				rsp_credit_i <= 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Link monitor, sampled mid cycle
	//////////////////////////////////////////////////////////////////////
	always @(negedge wb_clk_i) begin : watch_links
		logic [32:0] exp_rsp;
		if (rst_n_i) begin
			if (req_valid_i) begin
				req_sent++;
				if (req_sent > req_depth + req_credit_pulses) begin
					protocol_errors++;
					$display("Request sent without a credit at %0t ns", $time);
				end
			end
			if (req_credit_o) begin
				req_credit_pulses++;
				req_credits++;
			end
			if (rsp_valid_o) begin
				rsp_seen++;
				ret_pending++;
				if (rsp_seen > rsp_credits + rsp_returned) begin
					protocol_errors++;
					$display("Response sent without a credit at %0t ns", $time);
				end
				if (exp_q.size() == 0) begin
					protocol_errors++;
					$display("Response at %0t ns with no request waiting for it", $time);
				end else begin
					exp_rsp = exp_q.pop_front();
					check_value("rsp_err_o", rsp_err_o, exp_rsp[32]);
					check_value("rsp_dat_o", rsp_dat_o, exp_rsp[31:0]);
				end
			end
			if (rsp_credit_i)
				rsp_returned++;
		end
	end

	initial begin : run_test
		int                fd;
		int                n;
		int                lines;
		logic [8*160-1:0]  line_buf;
		logic [63:0]       op_name;
		logic [31:0]       adr;
		logic [31:0]       dat;
		logic [31:0]       rdat;
		logic [7:0]        pins;
		logic              err;
		rst_n_i = 1'b0;
		req_valid_i = 1'b0;
		req_we_i = 1'b0;
		req_adr_i = '0;
		req_dat_i = '0;
		gpio_i = '0;
		req_credits = req_depth;
		ret_pending = 0;
		req_sent = 0;
		req_credit_pulses = 0;
		rsp_seen = 0;
		rsp_returned = 0;
		value_errors = 0;
		protocol_errors = 0;
		timeouts = 0;
		model_dat = '0;
		model_dir = '0;
		lines = 0;

		repeat (2) @(posedge wb_clk_i);
		rst_n_i <= 1'b1;
		@(negedge wb_clk_i);
		check_value("rsp_valid_o", rsp_valid_o, 0);
		check_value("req_credit_o", req_credit_o, 0);
		check_value("gpio_o", gpio_o, 0);
		check_value("gpio_oe_o", gpio_oe_o, 0);
		@(posedge wb_clk_i);

		fd = $fopen("periph_input.txt", "r");
		if (fd == 0) begin
			protocol_errors++;
			$display("Could not open the data file periph_input.txt");
		end else begin
			while (!$feof(fd) && timeouts == 0) begin
				line_buf = '0;
				n = $fgets(line_buf, fd);
				n = $sscanf(line_buf, "%s %h %h %h %h %h", op_name, adr, dat, pins, err, rdat);
				// Comment and blank lines do not parse into six fields
				if (n == 6) begin
					if (pins !== gpio_i) begin
						drain_responses();
						gpio_i <= pins;
					end
					send_request(op_name == "write", adr, dat, {err, rdat});
					lines++;
				end
			end
			$fclose(fd);
			drain_responses();
			if (lines == 0) begin
				protocol_errors++;
				$display("The data file held no requests");
			end
			if (timeouts == 0 && req_credits != req_depth) begin
				protocol_errors++;
				$display("Request credits did not all come back, %0d of %0d held",
					req_credits, req_depth);
			end
		end
		finish_run();
	end

endmodule

`default_nettype wire

//--- periph_top.sv
`timescale 1ns/1ps
`default_nettype none

module periph_top #(
	parameter int req_depth = 4,
	parameter int rsp_depth = 4,
	parameter int rom_aw = 6,
	parameter int rsp_credits = 2
) (
	input  logic                 wb_clk_i,
	input  logic                 rst_n_i,
	// Request link
	input  logic                 req_valid_i,
	input  logic                 req_we_i,
	input  periph_pkg::bus_adr_t req_adr_i,
	input  periph_pkg::bus_dat_t req_dat_i,
	output logic                 req_credit_o,
	// Response link
	output logic                 rsp_valid_o,
	output logic                 rsp_err_o,
	output periph_pkg::bus_dat_t rsp_dat_o,
	input  logic                 rsp_credit_i,
	// GPIO pins
	input  periph_pkg::byte_t    gpio_i,
	output periph_pkg::byte_t    gpio_o,
	output periph_pkg::byte_t    gpio_oe_o
);

	periph_pkg::req_t    req_in;
	logic                req_head_valid;
	periph_pkg::req_t    req_head;
	logic                dec_valid;
	periph_pkg::req_t    dec_req;
	periph_pkg::target_e dec_tgt;
	logic                acc_valid;
	periph_pkg::rsp_t    acc_rsp;
	periph_pkg::rsp_t    rsp_head;
	logic                rsp_slot_free;

	assign req_in = '{we: req_we_i, adr: req_adr_i, dat: req_dat_i};
	assign rsp_err_o = rsp_head.err;
	assign rsp_dat_o = rsp_head.dat;

	//////////////////////////////////////////////////////////////////////
	// Request buffer, launches only into a free response slot
	//////////////////////////////////////////////////////////////////////
	credit_fifo #(
		.depth        (req_depth),
		.init_credits (rsp_depth),
		.payload_t    (periph_pkg::req_t)
	) u_req_fifo (
		.wb_clk_i    (wb_clk_i),
		.rst_n_i     (rst_n_i),
		.in_valid_i  (req_valid_i),
		.in_data_i   (req_in),
		.out_valid_o (req_head_valid),
		.out_data_o  (req_head),
		.credit_i    (rsp_slot_free),
		.credit_o    (req_credit_o)
	);

	addr_decode_stage #(
		.rom_aw (rom_aw)
	) u_addr_decode_stage (
		.wb_clk_i    (wb_clk_i),
		.rst_n_i     (rst_n_i),
		.in_valid_i  (req_head_valid),
		.in_req_i    (req_head),
		.out_valid_o (dec_valid),
		.out_req_o   (dec_req),
		.out_tgt_o   (dec_tgt)
	);

	target_access_stage #(
		.rom_aw (rom_aw)
	) u_target_access_stage (
		.wb_clk_i    (wb_clk_i),
		.rst_n_i     (rst_n_i),
		.in_valid_i  (dec_valid),
		.in_req_i    (dec_req),
		.in_tgt_i    (dec_tgt),
		.gpio_i      (gpio_i),
		.gpio_o      (gpio_o),
		.gpio_oe_o   (gpio_oe_o),
		.out_valid_o (acc_valid),
		.out_rsp_o   (acc_rsp)
	);

	// Response buffer, its pops hand slots back to the request side
	credit_fifo #(
		.depth        (rsp_depth),
		.init_credits (rsp_credits),
		.payload_t    (periph_pkg::rsp_t)
	) u_rsp_fifo (
		.wb_clk_i    (wb_clk_i),
		.rst_n_i     (rst_n_i),
		.in_valid_i  (acc_valid),
		.in_data_i   (acc_rsp),
		.out_valid_o (rsp_valid_o),
		.out_data_o  (rsp_head),
		.credit_i    (rsp_credit_i),
		.credit_o    (rsp_slot_free)
	);

endmodule

`default_nettype wire

//--- target_access_stage.sv
`timescale 1ns/1ps
`default_nettype none

module target_access_stage #(
	parameter int rom_aw = 6
) (
	input  logic                wb_clk_i,
	input  logic                rst_n_i,
	input  logic                in_valid_i,
	input  periph_pkg::req_t    in_req_i,
	input  periph_pkg::target_e in_tgt_i,
	input  periph_pkg::byte_t   gpio_i,
	output periph_pkg::byte_t   gpio_o,
	output periph_pkg::byte_t   gpio_oe_o,
	output logic                out_valid_o,
	output periph_pkg::rsp_t    out_rsp_o
);

	logic                 gpio_sel;
	logic [1:0]           lane;
	periph_pkg::byte_t    wr_byte;
	periph_pkg::byte_t    gpio_rdat;
	periph_pkg::bus_dat_t rom_dat;

	periph_pkg::target_e  tgt_q;
	logic                 we_q;
	logic [1:0]           lane_q;

	//////////////////////////////////////////////////////////////////////
	// 32 to 8 bit resize, lane picked by address bits 1:0
	//////////////////////////////////////////////////////////////////////
	assign gpio_sel = in_valid_i && (in_tgt_i == periph_pkg::TGT_GPIO);
	assign lane = in_req_i.adr[1:0];
	assign wr_byte = in_req_i.dat[8*lane +: 8];

	boot_rom #(
		.rom_aw (rom_aw)
	) u_boot_rom (
		.wb_clk_i (wb_clk_i),
		.adr_i    (in_req_i.adr[rom_aw+1:2]),
		.dat_o    (rom_dat)
	);

	gpio_regs u_gpio_regs (
		.wb_clk_i  (wb_clk_i),
		.rst_n_i   (rst_n_i),
		.wr_i      (gpio_sel && in_req_i.we),
		.rd_i      (gpio_sel && !in_req_i.we),
		.ofs_i     (in_req_i.adr[0]),
		.wdat_i    (wr_byte),
		.gpio_i    (gpio_i),
		.rdat_o    (gpio_rdat),
		.gpio_o    (gpio_o),
		.gpio_oe_o (gpio_oe_o)
	);

	always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			out_valid_o <= 1'b0;
		else
			out_valid_o <= in_valid_i;
	end

	// Travels alongside the ROM and GPIO read registers
	always_ff @(posedge wb_clk_i) begin
		tgt_q <= in_tgt_i;
		we_q <= in_req_i.we;
		lane_q <= lane;
	end

	// Response formed from the registered read data
	always_comb begin
		out_rsp_o = '0;
		case (tgt_q)
			periph_pkg::TGT_ROM:  out_rsp_o.dat = rom_dat;
			periph_pkg::TGT_GPIO: begin
				if (!we_q)
					out_rsp_o.dat = periph_pkg::bus_dat_t'(gpio_rdat) << (8 * lane_q);
			end
			default: out_rsp_o.err = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

//--- gpio_regs.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_regs (
	input  logic              wb_clk_i,
	input  logic              rst_n_i,
	input  logic              wr_i,
	input  logic              rd_i,
	input  logic              ofs_i,
	input  periph_pkg::byte_t wdat_i,
	input  periph_pkg::byte_t gpio_i,
	output periph_pkg::byte_t rdat_o,
	output periph_pkg::byte_t gpio_o,
	output periph_pkg::byte_t gpio_oe_o
);

	periph_pkg::byte_t dat_q;
	periph_pkg::byte_t dir_q;
	periph_pkg::byte_t pins;

	// Direction 1 drives the pin, 0 listens to it
	assign pins = (dat_q & dir_q) | (gpio_i & ~dir_q);

	assign gpio_o = dat_q;
	assign gpio_oe_o = dir_q;

	always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			dat_q <= '0;
			dir_q <= '0;
		end else if (wr_i) begin
			case (ofs_i)
				periph_pkg::GPIO_DATA_OFS[0]: dat_q <= wdat_i;
				periph_pkg::GPIO_DIR_OFS[0]:  dir_q <= wdat_i;
			endcase
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (rd_i)
			rdat_o <= (ofs_i == periph_pkg::GPIO_DIR_OFS[0]) ? dir_q : pins;
	end

endmodule

`default_nettype wire

//--- boot_rom.sv
`timescale 1ns/1ps
`default_nettype none

module boot_rom #(
	parameter int rom_aw = 6
) (
	input  logic                 wb_clk_i,
	input  logic [rom_aw-1:0]    adr_i,
	output periph_pkg::bus_dat_t dat_o
);

	//////////////////////////////////////////////////////////////////////
	// Registered read from the image table
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge wb_clk_i) begin
		case (adr_i)
`include "boot_rom_image.svh"
			// Unlisted words read as zero
			default: dat_o <= '0;
		endcase
	end

endmodule

`default_nettype wire

//--- addr_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module addr_decode_stage #(
	parameter int rom_aw = 6
) (
	input  logic                wb_clk_i,
	input  logic                rst_n_i,
	input  logic                in_valid_i,
	input  periph_pkg::req_t    in_req_i,
	output logic                out_valid_o,
	output periph_pkg::req_t    out_req_o,
	output periph_pkg::target_e out_tgt_o
);

	logic                rom_hit;
	logic                gpio_hit;
	periph_pkg::target_e tgt;

	// ROM window is 2**(rom_aw+2) bytes
	assign rom_hit = (in_req_i.adr >> (rom_aw + 2)) ==
		(periph_pkg::ROM_BASE >> (rom_aw + 2));
	assign gpio_hit = (in_req_i.adr >> 2) == (periph_pkg::GPIO_BASE >> 2);

	always_comb begin
		tgt = periph_pkg::TGT_NONE;
		// ROM writes fall through to the error target
		if (rom_hit && !in_req_i.we)
			tgt = periph_pkg::TGT_ROM;
		else if (gpio_hit)
			tgt = periph_pkg::TGT_GPIO;
	end

	always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			out_valid_o <= 1'b0;
		else
			out_valid_o <= in_valid_i;
	end

	always_ff @(posedge wb_clk_i) begin
		out_req_o <= in_req_i;
		out_tgt_o <= tgt;
	end

endmodule

`default_nettype wire

//--- credit_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
	parameter int depth = 4,
	parameter int init_credits = 2,
	parameter type payload_t = logic
) (
	input  logic     wb_clk_i,
	input  logic     rst_n_i,
	input  logic     in_valid_i,
	input  payload_t in_data_i,
	output logic     out_valid_o,
	output payload_t out_data_o,
	input  logic     credit_i,
	output logic     credit_o
);

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);
	localparam int crd_w = $clog2(init_credits + 1);

	payload_t mem [depth];

	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic [crd_w-1:0] credits;
	logic             pop;

	// Head leaves as soon as downstream has room for it
	assign pop = (count != '0) && (credits != '0);

	assign out_valid_o = pop;
	assign out_data_o = mem[rd_ptr];
	assign credit_o = pop;

	// Upstream credits guarantee a free slot
	always_ff @(posedge wb_clk_i) begin
		if (in_valid_i)
			mem[wr_ptr] <= in_data_i;
	end

	always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credits <= crd_w'(init_credits);
		end else begin
			if (in_valid_i)
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;

			case ({in_valid_i, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase

			// Downstream credit counter
			case ({credit_i, pop})
				2'b10:   credits <= credits + 1'b1;
				2'b01:   credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- periph_pkg.sv
`default_nettype none

package periph_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bus widths and basic types
	//////////////////////////////////////////////////////////////////////
	localparam int BUS_DW = 32;
	localparam int BUS_AW = 32;

	typedef logic [BUS_AW-1:0] bus_adr_t;
	typedef logic [BUS_DW-1:0] bus_dat_t;
	typedef logic [7:0] byte_t;

	//////////////////////////////////////////////////////////////////////
	// Address map
	//////////////////////////////////////////////////////////////////////
	// ROM window size follows rom_aw, see addr_decode_stage
	localparam bus_adr_t ROM_BASE = 32'hF000_0000;
	// 4 byte window, offsets 2 and 3 alias onto 0 and 1
	localparam bus_adr_t GPIO_BASE = 32'h9100_0000;

	localparam int unsigned GPIO_DATA_OFS = 0;
	localparam int unsigned GPIO_DIR_OFS = 1;

	typedef enum logic [1:0] {
		TGT_ROM  = 2'd0,
		TGT_GPIO = 2'd1,
		TGT_NONE = 2'd2
	} target_e;

	// Request and response payloads
	typedef struct packed {
		logic     we;
		bus_adr_t adr;
		bus_dat_t dat;
	} req_t;

	typedef struct packed {
		logic     err;
		bus_dat_t dat;
	} rsp_t;

endpackage

`default_nettype wire

//--- boot_rom_image.svh
`ifndef BOOT_ROM_IMAGE_SVH
`define BOOT_ROM_IMAGE_SVH

// Boot image, one case item per word index
// Loads the flash base and jumps to it
			0:  dat_o <= 32'h1880_0000;
			1:  dat_o <= 32'hA884_0100;
			2:  dat_o <= 32'h1860_9100;
			3:  dat_o <= 32'hA863_0000;
			4:  dat_o <= 32'h9C40_00FF;
			5:  dat_o <= 32'hD803_1001;
			6:  dat_o <= 32'hD803_1000;
			7:  dat_o <= 32'h1800_F000;
			8:  dat_o <= 32'hA800_0200;
			9:  dat_o <= 32'h4400_0000;
			10: dat_o <= 32'h1500_0000;
			11: dat_o <= 32'h0000_0000;
			12: dat_o <= 32'hDEAD_BEEF;
			13: dat_o <= 32'hCAFE_F00D;
			14: dat_o <= 32'h1234_5678;
			15: dat_o <= 32'h8765_4321;

`endif
